/* verilog/seq_pkg.sv */
// Shared sizes, opcode and unit encodings and bus structs, imported by every sequencer block
package seq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Number of instructions that can be in flight at once
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Architectural vector register file
  localparam int unsigned NrVRegs = 32;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // Functional units that take instructions from the sequencer
  localparam int unsigned NrUnits = 4;

  // Operands that a hazard bit can point at
  localparam int unsigned NrHazardOps = 3;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  // Two encodings of the 3-bit field stay unused
  typedef enum logic [2:0] {
    OP_VADD,
    OP_VSUB,
    OP_VMUL,
    OP_VMACC,
    OP_VLE,
    OP_VSE
  } op_e;

  // Index into the third dimension of a hazard table
  typedef enum logic [1:0] {
    H_VS1,
    H_VS2,
    H_VD
  } hazard_op_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Decoded instruction as it arrives from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } seq_req_t;

  // Instruction as it leaves towards a unit, tagged with its ID and target
  typedef struct packed {
    vid_t  id;
    unit_e unit;
    op_e   op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } pe_req_t;

  // Single-cycle completion report from one unit
  typedef struct packed {
    logic valid;
    vid_t id;
  } pe_done_t;

  // Row is the dependent instruction, column the instruction it waits on
  typedef logic [NrVInsn-1:0][NrVInsn-1:0][NrHazardOps-1:0] hazard_tbl_t;

  // Each opcode runs on exactly one unit
  function automatic unit_e op_unit(op_e op);
    unit_e unit;
    case (op)
      OP_VADD, OP_VSUB:  unit = UNIT_ALU;
      OP_VMUL, OP_VMACC: unit = UNIT_MUL;
      OP_VLE:            unit = UNIT_LOAD;
      OP_VSE:            unit = UNIT_STORE;
      default:           unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

/* verilog/vinsn_tracker.sv */
// Keeps the set of running instruction IDs and offers the lowest free ID to the issue logic
`timescale 1ns/1ns

module vinsn_tracker (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Allocation from the issue logic
  input  logic                                     alloc_i,
  input  seq_pkg::vid_t                            alloc_id_i,
  // Completion reports, one per unit
  input  seq_pkg::pe_done_t [seq_pkg::NrUnits-1:0] pe_done_i,
  output logic              [seq_pkg::NrVInsn-1:0] running_o,
  output seq_pkg::vid_t                            next_id_o,
  output logic                                     id_free_o,
  output logic                                     idle_o
);

  import seq_pkg::*;

  // One bit per ID, set while the instruction is somewhere in a unit
  logic [NrVInsn-1:0] running_d, running_q;
  logic [NrVInsn-1:0] done_mask;

  ////////////////////////////////////////
  // Running vector
  ////////////////////////////////////////

  // Any unit may retire any ID, so OR all reports into one mask
  always_comb begin
    done_mask = '0;
    for (int unsigned u = 0; u < NrUnits; u++) begin
      if (pe_done_i[u].valid) done_mask[pe_done_i[u].id] = 1'b1;
    end
  end

  always_comb begin
    running_d = running_q & ~done_mask;
    if (alloc_i) running_d[alloc_id_i] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  ////////////////////////////////////////
  // Lowest free ID
  ////////////////////////////////////////

  // Walking down from the top leaves the lowest clear bit as the result
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id_o = vid_t'(i);
    end
  end

  assign id_free_o = ~&running_q;
  assign idle_o    = ~|running_q;
  assign running_o = running_q;

  // A unit can only retire an instruction that was handed out and not yet retired
  for (genvar u = 0; u < NrUnits; u++) begin : gen_done_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_done_i[u].valid |-> running_q[pe_done_i[u].id])
      else $error("Unit %0d reported done for idle ID %0d", u, pe_done_i[u].id);
  end

endmodule

/* verilog/unit_queue_ctrl.sv */
// Counts the instructions queued at each functional unit and flags which units can take more
`timescale 1ns/1ns

module unit_queue_ctrl #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Acceptance pulse and the unit the accepted instruction targets
  input  logic                                     accept_i,
  input  seq_pkg::unit_e                           accept_unit_i,
  // A done report frees one slot at its unit
  input  seq_pkg::pe_done_t [seq_pkg::NrUnits-1:0] pe_done_i,
  output logic              [seq_pkg::NrUnits-1:0] unit_room_o
);

  import seq_pkg::*;

  // Wide enough to hold QueueDepth itself
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  ////////////////////////////////////////
  // Per-unit counters
  ////////////////////////////////////////

  for (genvar u = 0; u < NrUnits; u++) begin : gen_unit_cnt

    logic [CntWidth-1:0] cnt_q;
    logic                inc;
    logic                dec;

    // Instructions are counted when accepted, not when the unit takes them
    assign inc = accept_i && (accept_unit_i == unit_e'(u));
    assign dec = pe_done_i[u].valid;

    // An increment and a decrement in the same cycle leave the count alone
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (inc && !dec) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (dec && !inc) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Room while the queue still has a slot
    assign unit_room_o[u] = (cnt_q < CntWidth'(QueueDepth));

    // The ready logic must never let a full unit take another instruction
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q <= CntWidth'(QueueDepth))
      else $error("Queue counter of unit %0d above depth", u);

    // A done report must match an instruction counted earlier at this unit
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(dec && !inc && (cnt_q == '0)))
      else $error("Queue counter of unit %0d would wrap below zero", u);

  end

endmodule

/* verilog/hazard_tracker.sv */
// Builds the RAW/WAW and WAR/WAW dependency tables between running instructions for the operand requesters
`timescale 1ns/1ns

module hazard_tracker (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Instruction accepted this cycle and the ID it receives
  input  logic                                  accept_i,
  input  seq_pkg::seq_req_t                     req_i,
  input  seq_pkg::vid_t                         new_id_i,
  input  logic           [seq_pkg::NrVInsn-1:0] running_i,
  // RAW on sources and WAW on vd
  output seq_pkg::hazard_tbl_t                  hazard_tbl_o,
  // WAR on the reader's operand and WAW on vd
  output seq_pkg::hazard_tbl_t                  write_hazard_tbl_o
);

  import seq_pkg::*;

  // Read entry remembers which operand slot the reader uses
  typedef struct packed {
    hazard_op_e op;
    logic       valid;
  } read_entry_t;

  // Per register, one bit or entry per instruction ID
  logic        [NrVRegs-1:0][NrVInsn-1:0] write_list_d, write_list_q;
  read_entry_t [NrVRegs-1:0][NrVInsn-1:0] read_list_d, read_list_q;

  // Row of the new instruction in each table
  logic [NrVInsn-1:0][NrHazardOps-1:0] raw_row, war_row;

  hazard_tbl_t hazard_d, hazard_q;
  hazard_tbl_t write_hazard_d, write_hazard_q;

  ////////////////////////////////////////
  // Register access lists
  ////////////////////////////////////////

  always_comb begin
    write_list_d = write_list_q;
    read_list_d  = read_list_q;
    // Entries of finished instructions drop out here
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      write_list_d[r] &= running_i;
      for (int unsigned j = 0; j < NrVInsn; j++) begin
        read_list_d[r][j].valid &= running_i[j];
      end
    end

    // New row is taken from the pruned lists, before the new instruction joins them
    raw_row = '0;
    war_row = '0;
    for (int unsigned j = 0; j < NrVInsn; j++) begin
      if (req_i.use_vs1) raw_row[j][H_VS1] = write_list_d[req_i.vs1][j];
      if (req_i.use_vs2) raw_row[j][H_VS2] = write_list_d[req_i.vs2][j];
      if (req_i.use_vd) begin
        // WAW shows up in both tables
        raw_row[j][H_VD] = write_list_d[req_i.vd][j];
        war_row[j][H_VD] = write_list_d[req_i.vd][j];
        // WAR lands on the operand slot the older reader uses
        if (read_list_d[req_i.vd][j].valid) war_row[j][read_list_d[req_i.vd][j].op] = 1'b1;
      end
    end

    // Now record what the accepted instruction reads and writes
    if (accept_i) begin
      if (req_i.use_vd) write_list_d[req_i.vd][new_id_i] = 1'b1;
      if (req_i.use_vs1) read_list_d[req_i.vs1][new_id_i] = '{op: H_VS1, valid: 1'b1};
      if (req_i.use_vs2) read_list_d[req_i.vs2][new_id_i] = '{op: H_VS2, valid: 1'b1};
    end
  end

  ////////////////////////////////////////
  // Hazard tables
  ////////////////////////////////////////

  always_comb begin
    hazard_d       = hazard_q;
    write_hazard_d = write_hazard_q;
    // Columns of finished instructions clear one cycle after their running bit
    for (int unsigned i = 0; i < NrVInsn; i++) begin
      for (int unsigned j = 0; j < NrVInsn; j++) begin
        hazard_d[i][j]       &= {NrHazardOps{running_i[j]}};
        write_hazard_d[i][j] &= {NrHazardOps{running_i[j]}};
      end
    end
    // The row of a reused ID is replaced as a whole
    if (accept_i) begin
      hazard_d[new_id_i]       = raw_row;
      write_hazard_d[new_id_i] = war_row;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_list_q   <= '0;
      read_list_q    <= '0;
      hazard_q       <= '0;
      write_hazard_q <= '0;
    end else begin
      write_list_q   <= write_list_d;
      read_list_q    <= read_list_d;
      hazard_q       <= hazard_d;
      write_hazard_q <= write_hazard_d;
    end
  end

  assign hazard_tbl_o       = hazard_q;
  assign write_hazard_tbl_o = write_hazard_q;

endmodule

/* verilog/issue_ctrl.sv */
// Accepts dispatcher requests when an ID and a queue slot are free and holds the unit request until taken
`timescale 1ns/1ns

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher handshake
  input  seq_pkg::seq_req_t             req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  // Resources offered by the tracker and the queue counters
  input  seq_pkg::vid_t                 next_id_i,
  input  logic                          id_free_i,
  input  logic [seq_pkg::NrUnits-1:0]   unit_room_i,
  // Acceptance towards the bookkeeping blocks
  output logic                          accept_o,
  output seq_pkg::unit_e                accept_unit_o,
  // Unit handshake
  output seq_pkg::pe_req_t              pe_req_o,
  output logic                          pe_req_valid_o,
  input  logic [seq_pkg::NrUnits-1:0]   pe_req_ready_i
);

  import seq_pkg::*;

  // HOLD covers the whole time a unit request is outstanding
  typedef enum logic {
    IDLE,
    HOLD
  } state_e;

  state_e  state_d, state_q;
  unit_e   req_unit;
  pe_req_t pe_req_q;
  logic    consume;

  ////////////////////////////////////////
  // Dispatcher side
  ////////////////////////////////////////

  assign req_unit = op_unit(req_i.op);

  // Only one request in flight towards the units, and it needs an ID and a slot
  assign req_ready_o   = (state_q == IDLE) && id_free_i && unit_room_i[req_unit];
  assign accept_o      = req_valid_i && req_ready_o;
  assign accept_unit_o = req_unit;

  ////////////////////////////////////////
  // Unit side
  ////////////////////////////////////////

  // Only the ready bit of the targeted unit matters
  assign consume = pe_req_valid_o && pe_req_ready_i[pe_req_q.unit];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (accept_o) state_d = HOLD;
      HOLD: if (consume) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured once on acceptance and left alone while the unit stalls
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      pe_req_q <= '{
        id:      next_id_i,
        unit:    req_unit,
        op:      req_i.op,
        vd:      req_i.vd,
        vs1:     req_i.vs1,
        vs2:     req_i.vs2,
        use_vd:  req_i.use_vd,
        use_vs1: req_i.use_vs1,
        use_vs2: req_i.use_vs2
      };
    end
  end

  assign pe_req_o       = pe_req_q;
  assign pe_req_valid_o = (state_q == HOLD);

  // A stalled request keeps its valid and its payload until the unit takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !consume |=> pe_req_valid_o && $stable(pe_req_o))
    else $error("Unit request changed before it was consumed");

endmodule

/* verilog/vector_sequencer.sv */
// Top of the vector instruction sequencer, sits between the dispatcher and the functional units
`timescale 1ns/1ns

module vector_sequencer #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t                        req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  // Functional units
  output seq_pkg::pe_req_t                         pe_req_o,
  output logic                                     pe_req_valid_o,
  input  logic              [seq_pkg::NrUnits-1:0] pe_req_ready_i,
  input  seq_pkg::pe_done_t [seq_pkg::NrUnits-1:0] pe_done_i,
  // Operand requesters
  output seq_pkg::hazard_tbl_t                     hazard_tbl_o,
  output seq_pkg::hazard_tbl_t                     write_hazard_tbl_o,
  output logic                                     idle_o
);

  import seq_pkg::*;

  logic [NrVInsn-1:0] running;
  vid_t               next_id;
  logic               id_free;
  logic [NrUnits-1:0] unit_room;
  logic               accept;
  unit_e              accept_unit;

  vinsn_tracker u_vinsn_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alloc_i    (accept),
    .alloc_id_i (next_id),
    .pe_done_i  (pe_done_i),
    .running_o  (running),
    .next_id_o  (next_id),
    .id_free_o  (id_free),
    .idle_o     (idle_o)
  );

  unit_queue_ctrl #(
    .QueueDepth (QueueDepth)
  ) u_unit_queue_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .accept_unit_i (accept_unit),
    .pe_done_i     (pe_done_i),
    .unit_room_o   (unit_room)
  );

  // The new ID is the one the tracker offers in the accepting cycle
  hazard_tracker u_hazard_tracker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .accept_i           (accept),
    .req_i              (req_i),
    .new_id_i           (next_id),
    .running_i          (running),
    .hazard_tbl_o       (hazard_tbl_o),
    .write_hazard_tbl_o (write_hazard_tbl_o)
  );

  issue_ctrl u_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .next_id_i      (next_id),
    .id_free_i      (id_free),
    .unit_room_i    (unit_room),
    .accept_o       (accept),
    .accept_unit_o  (accept_unit),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_req_ready_i (pe_req_ready_i)
  );

endmodule

/* dv/seq_checker.sv */
// Monitor for the sequencer testbench, predicts ready, IDs, unit requests and hazard tables
`timescale 1ns/1ns

module seq_checker #(
  parameter int unsigned QueueDepth = 2
) (
  input logic                                     clk_i,
  input logic                                     rst_ni,
  input seq_pkg::seq_req_t                        req_i,
  input logic                                     req_valid_i,
  input logic                                     req_ready_i,
  input seq_pkg::pe_req_t                         pe_req_i,
  input logic                                     pe_req_valid_i,
  input logic              [seq_pkg::NrUnits-1:0] pe_req_ready_i,
  input seq_pkg::pe_done_t [seq_pkg::NrUnits-1:0] pe_done_i,
  input seq_pkg::hazard_tbl_t                     hazard_tbl_i,
  input seq_pkg::hazard_tbl_t                     write_hazard_tbl_i,
  input logic                                     idle_i,
  // High while the stimulus expects the request to be refused
  input logic                                     expect_block_i
);

  import seq_pkg::*;

  // Model state: running set, queue counts and per-register access lists
  logic [NrVInsn-1:0] running;
  int unsigned        cnt [NrUnits];
  logic [NrVInsn-1:0] writers [NrVRegs];
  logic [NrVInsn-1:0] rd_vs1 [NrVRegs];
  logic [NrVInsn-1:0] rd_vs2 [NrVRegs];
  hazard_tbl_t        exp_haz, exp_whaz;
  pe_req_t            exp_pe;
  logic               hold;
  int                 error_count = 0;

  // ALU takes add and subtract, MUL takes both multiplies, memory ops go to their own unit
  function automatic unit_e unit_of(op_e op);
    unit_e unit;
    case (op)
      OP_VMUL, OP_VMACC: unit = UNIT_MUL;
      OP_VLE:            unit = UNIT_LOAD;
      OP_VSE:            unit = UNIT_STORE;
      default:           unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

  function automatic vid_t lowest_free(logic [NrVInsn-1:0] run);
    vid_t id;
    logic found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < NrVInsn; i++) begin
      if (!found && !run[i]) begin
        id    = vid_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("** Error @ %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // Compare, then advance the model
  ////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin : model
    logic [NrVInsn-1:0][NrHazardOps-1:0] raw_row, war_row;
    vid_t  id;
    unit_e unit;
    logic  accept;
    logic  exp_ready;
    if (!rst_ni) begin
      running  = '0;
      hold     = 1'b0;
      exp_haz  = '0;
      exp_whaz = '0;
      for (int u = 0; u < NrUnits; u++) cnt[u] = 0;
      for (int r = 0; r < NrVRegs; r++) begin
        writers[r] = '0;
        rd_vs1[r]  = '0;
        rd_vs2[r]  = '0;
      end
    end else begin
      // Ready needs an idle issue stage, a free ID and a slot at the target unit
      exp_ready = !hold && (running != '1) && (cnt[unit_of(req_i.op)] < QueueDepth);
      if (req_ready_i !== exp_ready)
        report_mismatch($sformatf("req_ready_o is %b, expected %b", req_ready_i, exp_ready));
      if (pe_req_valid_i !== hold)
        report_mismatch($sformatf("pe_req_valid_o is %b, expected %b", pe_req_valid_i, hold));
      if (hold && (pe_req_i !== exp_pe))
        report_mismatch($sformatf("pe_req_o is %h, expected %h", pe_req_i, exp_pe));
      if (hazard_tbl_i !== exp_haz)
        report_mismatch($sformatf("hazard_tbl_o is %h, expected %h", hazard_tbl_i, exp_haz));
      if (write_hazard_tbl_i !== exp_whaz)
        report_mismatch($sformatf("write_hazard_tbl_o is %h, expected %h",
                                  write_hazard_tbl_i, exp_whaz));
      if (idle_i !== (running == '0))
        report_mismatch($sformatf("idle_o is %b with running set %b", idle_i, running));

      accept = req_valid_i && req_ready_i;
      if (accept && expect_block_i)
        report_mismatch("request accepted although its unit queue should be full");

      // The unit takes the held request when its own ready bit is high
      if (hold && pe_req_ready_i[exp_pe.unit]) hold = 1'b0;

      // Columns of IDs that stopped running one edge earlier drop out now
      for (int j = 0; j < NrVInsn; j++) begin
        if (!running[j]) begin
          for (int i = 0; i < NrVInsn; i++) begin
            exp_haz[i][j]  = '0;
            exp_whaz[i][j] = '0;
          end
        end
      end

      if (accept) begin
        id   = lowest_free(running);
        unit = unit_of(req_i.op);
        for (int j = 0; j < NrVInsn; j++) begin
          raw_row[j] = '0;
          war_row[j] = '0;
          if (req_i.use_vs1 && writers[req_i.vs1][j]) raw_row[j][H_VS1] = 1'b1;
          if (req_i.use_vs2 && writers[req_i.vs2][j]) raw_row[j][H_VS2] = 1'b1;
          if (req_i.use_vd && writers[req_i.vd][j]) begin
            raw_row[j][H_VD] = 1'b1;
            war_row[j][H_VD] = 1'b1;
          end
          // WAR bit goes on the operand through which the older instruction reads vd
          if (req_i.use_vd && rd_vs1[req_i.vd][j]) war_row[j][H_VS1] = 1'b1;
          if (req_i.use_vd && rd_vs2[req_i.vd][j]) war_row[j][H_VS2] = 1'b1;
        end
        exp_haz[id]  = raw_row;
        exp_whaz[id] = war_row;
        // ID and unit lead, the dispatcher fields follow in their own order
        exp_pe = {id, unit, req_i};
        hold   = 1'b1;
        running[id] = 1'b1;
        cnt[unit]++;
        if (req_i.use_vd) writers[req_i.vd][id] = 1'b1;
        if (req_i.use_vs1) rd_vs1[req_i.vs1][id] = 1'b1;
        if (req_i.use_vs2) rd_vs2[req_i.vs2][id] = 1'b1;
      end

      // A done report retires the ID and frees a slot at the reporting unit
      for (int u = 0; u < NrUnits; u++) begin
        if (pe_done_i[u].valid) begin
          running[pe_done_i[u].id] = 1'b0;
          cnt[u]--;
          for (int r = 0; r < NrVRegs; r++) begin
            writers[r][pe_done_i[u].id] = 1'b0;
            rd_vs1[r][pe_done_i[u].id]  = 1'b0;
            rd_vs2[r][pe_done_i[u].id]  = 1'b0;
          end
        end
      end
    end
  end

endmodule

/* dv/tb_vector_sequencer.sv */
// Testbench top that applies a table of requests, unit stalls and done reports to the sequencer
`timescale 1ns/1ns

module tb_vector_sequencer;

  import seq_pkg::*;

  localparam int unsigned QueueDepth = 2;
  localparam int          Timeout    = 50;

  // One row of the stimulus table
  typedef struct packed {
    seq_req_t           req;
    logic [3:0]         stall;
    logic [NrVInsn-1:0] done;
    logic               block;
  } step_t;

  logic                    clk;
  logic                    rst_n;
  seq_req_t                req;
  logic                    req_valid;
  logic                    req_ready;
  pe_req_t                 pe_req;
  logic                    pe_req_valid;
  logic [NrUnits-1:0]      pe_req_ready;
  pe_done_t [NrUnits-1:0]  pe_done;
  hazard_tbl_t             haz_tbl;
  hazard_tbl_t             whaz_tbl;
  logic                    idle;
  logic                    expect_block;

  step_t              steps [$];
  // Done reports come from the unit each ID was issued to
  unit_e              id_unit [NrVInsn];
  logic [NrVInsn-1:0] tb_running;
  int                 timeouts = 0;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  vector_sequencer #(
    .QueueDepth (QueueDepth)
  ) u_vector_sequencer (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_i              (req),
    .req_valid_i        (req_valid),
    .req_ready_o        (req_ready),
    .pe_req_o           (pe_req),
    .pe_req_valid_o     (pe_req_valid),
    .pe_req_ready_i     (pe_req_ready),
    .pe_done_i          (pe_done),
    .hazard_tbl_o       (haz_tbl),
    .write_hazard_tbl_o (whaz_tbl),
    .idle_o             (idle)
  );

  seq_checker #(
    .QueueDepth (QueueDepth)
  ) u_seq_checker (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_i              (req),
    .req_valid_i        (req_valid),
    .req_ready_i        (req_ready),
    .pe_req_i           (pe_req),
    .pe_req_valid_i     (pe_req_valid),
    .pe_req_ready_i     (pe_req_ready),
    .pe_done_i          (pe_done),
    .hazard_tbl_i       (haz_tbl),
    .write_hazard_tbl_i (whaz_tbl),
    .idle_i             (idle),
    .expect_block_i     (expect_block)
  );

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  task automatic add_step(input op_e op, input int vd, input int vs1, input int vs2,
                          input logic [2:0] use_ops, input int stall,
                          input logic [NrVInsn-1:0] done, input logic block);
    step_t s;
    s.req.op  = op;
    s.req.vd  = vreg_t'(vd);
    s.req.vs1 = vreg_t'(vs1);
    s.req.vs2 = vreg_t'(vs2);
    {s.req.use_vd, s.req.use_vs1, s.req.use_vs2} = use_ops;
    s.stall = 4'(stall);
    s.done  = done;
    s.block = block;
    steps.push_back(s);
  endtask

  // Filler rows get random registers and keep the two sources apart
  task automatic add_filler(input op_e op, input logic [2:0] use_ops,
                            input logic [NrVInsn-1:0] done);
    int vd;
    int vs1;
    int vs2;
    vd  = $urandom_range(0, NrVRegs - 1);
    vs1 = $urandom_range(0, NrVRegs - 1);
    vs2 = (vs1 + 1 + $urandom_range(0, NrVRegs - 2)) % NrVRegs;
    add_step(op, vd, vs1, vs2, use_ops, 0, done, 1'b0);
  endtask

  task automatic build_table();
    // op, vd, vs1, vs2, operands used {vd vs1 vs2}, unit stall, IDs done first, refused
    add_step(OP_VADD,  1,  2,  3, 3'b111, 0, 8'h00, 1'b0);
    add_step(OP_VMUL,  4,  1,  5, 3'b111, 3, 8'h00, 1'b0);
    add_step(OP_VADD,  2,  4,  1, 3'b111, 0, 8'h00, 1'b0);
    // ALU queue holds two so this one waits for a done report
    add_step(OP_VSUB,  6,  7,  8, 3'b111, 0, 8'h00, 1'b1);
    add_step(OP_VSUB,  6,  7,  8, 3'b111, 0, 8'h01, 1'b0);
    add_step(OP_VLE,   1,  0,  0, 3'b100, 1, 8'h00, 1'b0);
    add_step(OP_VMACC, 4,  1,  4, 3'b111, 2, 8'h00, 1'b0);
    add_step(OP_VSE,   0,  4,  0, 3'b010, 0, 8'h00, 1'b0);
    add_step(OP_VMUL,  9, 10, 11, 3'b111, 0, 8'h00, 1'b1);
    add_step(OP_VMUL,  9, 10, 11, 3'b111, 0, 8'h02, 1'b0);
    add_filler(OP_VADD, 3'b111, 8'h05);
    add_filler(OP_VSUB, 3'b111, 8'h00);
    add_filler(OP_VLE,  3'b100, 8'h00);
    add_filler(OP_VSE,  3'b010, 8'h00);
    add_filler(OP_VMUL, 3'b111, 8'h38);
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Each ID is reported by the unit it went to with one report per cycle
  task automatic report_done(input logic [NrVInsn-1:0] ids);
    for (int i = 0; i < NrVInsn; i++) begin
      if (ids[i]) begin
        @(posedge clk);
        pe_done <= '0;
        pe_done[id_unit[i]] <= {1'b1, vid_t'(i)};
        tb_running[i] = 1'b0;
      end
    end
    @(posedge clk);
    pe_done <= '0;
  endtask

  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!req_ready && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    ok = req_ready;
    if (!ok) begin
      $display("Timeout: request with opcode %0d was never accepted", req.op);
      timeouts++;
    end
  endtask

  task automatic wait_consumed();
    int n;
    n = 0;
    @(negedge clk);
    while (pe_req_valid && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    if (pe_req_valid) begin
      $display("Timeout: unit request for ID %0d was never taken", pe_req.id);
      timeouts++;
    end
  endtask

  task automatic run_step(input step_t s);
    logic ok;
    report_done(s.done);
    @(posedge clk);
    pe_req_ready <= (s.stall == 0) ? '1 : '0;
    req          <= s.req;
    req_valid    <= 1'b1;
    expect_block <= s.block;
    if (s.block) begin
      repeat (4) @(posedge clk);
      req_valid    <= 1'b0;
      expect_block <= 1'b0;
    end else begin
      wait_ready(ok);
      // Handshake edge
      @(posedge clk);
      req_valid <= 1'b0;
      if (ok) begin
        @(negedge clk);
        if (pe_req_valid) begin
          id_unit[pe_req.id]    = pe_req.unit;
          tb_running[pe_req.id] = 1'b1;
        end
        // A stalled unit turns ready after the tabled number of cycles
        if (s.stall != 0) begin
          repeat (s.stall) @(posedge clk);
          pe_req_ready <= '1;
        end
        wait_consumed();
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int n;
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    pe_req_ready = '1;
    pe_done      = '0;
    expect_block = 1'b0;
    tb_running   = '0;
    void'($urandom(32'ha3360bea));
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    for (int k = 0; k < steps.size(); k++) begin
      run_step(steps[k]);
    end

    // Retire everything still running and let the hazard columns drain
    report_done(tb_running);
    n = 0;
    @(negedge clk);
    while (!idle && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    if (!idle) begin
      $display("Timeout: sequencer did not go idle after all done reports");
      timeouts++;
    end
    repeat (3) @(posedge clk);

    $display("Closing: %0d mismatches, %0d timeouts", u_seq_checker.error_count, timeouts);
    if (u_seq_checker.error_count == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/seq_pkg.sv
verilog/vinsn_tracker.sv
verilog/unit_queue_ctrl.sv
verilog/hazard_tracker.sv
verilog/issue_ctrl.sv
verilog/vector_sequencer.sv
dv/seq_checker.sv
dv/tb_vector_sequencer.sv
